// ==== hdl/cpu_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

module cpu_channel (
    input  logic                        mclk,
    input  logic                        resetn,
    loader_if.channel                   ld,
    input  logic [`ROM_ADDR_W-1:0]      rom_addr,
    input  logic                        rom_ce_n,
    input  logic                        rom_word,
    output snes_mem_pkg::sdram_word_u   rom_q,
    input  logic [`WRAM_ADDR_W-1:0]     wram_addr,
    input  logic                        wram_ce_n,
    input  logic                        wram_rd_n,
    input  logic                        wram_we_n,
    input  logic [7:0]                  wram_d,
    output logic [7:0]                  wram_q,
    output logic                        cpu_req,
    output logic                        cpu_we,
    output logic                        cpu_port,
    output logic [`ROM_ADDR_W-2:0]      cpu_addr,
    output snes_mem_pkg::sdram_word_u   cpu_din,
    output logic [1:0]                  cpu_ds,
    input  snes_mem_pkg::sdram_word_u   cpu_port0,
    input  snes_mem_pkg::sdram_word_u   cpu_port1
);
    logic [`ROM_ADDR_W-1:0]     rom_addr_cur;
    logic [`ROM_ADDR_W-1:0]     rom_addr_sd;    // Last ROM address sent
    logic [`WRAM_ADDR_W-2:0]    wram_word_sd;   // Last WRAM word sent
    logic                       wram_rd;
    logic                       wram_wr;
    logic                       wram_rd_r;
    logic                       wram_wr_r;
    logic                       load_hit;
    logic                       rom_hit;
    logic                       wram_hit;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // Loader owns the ROM address while an image streams in
    assign rom_addr_cur = ld.loading ? ld.wr_addr : rom_addr;

    assign load_hit = ld.loading & ld.wr_stb;
    assign rom_hit  = ~ld.loading & ~rom_ce_n & (rom_addr_cur != rom_addr_sd);

    // New read edge, read moving to another word, or new write edge
    assign wram_hit = (wram_rd & (wram_addr[`WRAM_ADDR_W-1:1] != wram_word_sd))
                    | (wram_rd & ~wram_rd_r)
                    | (wram_wr & ~wram_wr_r);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_req      <= 1'b0;
            rom_addr_sd  <= '0;
            wram_word_sd <= '0;
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;

            if (load_hit || rom_hit) begin
                rom_addr_sd <= rom_addr_cur;
                cpu_req     <= ~cpu_req;
                cpu_addr    <= rom_addr_cur[`ROM_ADDR_W-1:1];
                cpu_we      <= ld.loading;
                cpu_din     <= ld.wr_data;
                cpu_ds      <= 2'b11;
                cpu_port    <= 1'b0;
            end

            // Later in the block, so WRAM takes the slot on a clash
            if (wram_hit) begin
                wram_word_sd      <= wram_addr[`WRAM_ADDR_W-1:1];
                cpu_req           <= ~cpu_req;
                cpu_addr          <= {`WRAM_BASE_TAG, wram_addr[`WRAM_ADDR_W-1:1]};
                cpu_we            <= wram_wr;
                cpu_din.bytes[0]  <= wram_d;
                cpu_din.bytes[1]  <= wram_d;
                cpu_ds            <= {wram_addr[0], ~wram_addr[0]};  // One lane only
                cpu_port          <= 1'b1;
            end
        end
    end

    // Odd byte fetch sees its byte first
    always_comb begin
        if (rom_word || !rom_addr[0]) begin
            rom_q.word = cpu_port0.word;
        end else begin
            rom_q.bytes[0] = cpu_port0.bytes[1];
            rom_q.bytes[1] = cpu_port0.bytes[0];
        end
    end

    assign wram_q = cpu_port1.bytes[wram_addr[0]];

endmodule

`default_nettype wire

// ==== hdl/loader_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

interface loader_if;
    logic                       loading;
    logic                       wr_stb;     // One cycle per paired word
    logic [`ROM_ADDR_W-1:0]     wr_addr;    // Always even
    snes_mem_pkg::sdram_word_u  wr_data;    // Earlier byte in lane 0

    modport loader (output loading, output wr_stb, output wr_addr, output wr_data);
    modport channel (input loading, input wr_stb, input wr_addr, input wr_data);
endinterface

`default_nettype wire

// ==== hdl/rom_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

module rom_loader (
    input  logic        mclk,
    input  logic        resetn,
    input  logic        loading,
    input  logic [7:0]  loader_byte,
    input  logic        loader_byte_valid,
    output logic        loaded,
    loader_if.loader    ld
);
    localparam int HDR_CNT_W = $clog2(`HEADER_BYTES + 1);

    logic                   loading_r;
    logic                   load_start;
    logic                   take_byte;
    logic                   hdr_done;
    logic [HDR_CNT_W-1:0]   hdr_cnt;
    logic [HDR_CNT_W-1:0]   hdr_cur;
    logic [`ROM_ADDR_W-1:0] load_addr;
    logic [`ROM_ADDR_W-1:0] addr_cur;
    logic [7:0]             prev_byte;

    assign load_start = loading & ~loading_r;
    assign take_byte  = loading & loader_byte_valid;

    // A byte that comes with the rising edge of loading already belongs to the new image
    assign hdr_cur  = load_start ? '0 : hdr_cnt;
    assign addr_cur = load_start ? '0 : load_addr;
    assign hdr_done = hdr_cur == HDR_CNT_W'(`HEADER_BYTES);

    assign ld.loading = loading;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            hdr_cnt   <= '0;
            load_addr <= '0;
            loaded    <= 1'b0;
            ld.wr_stb <= 1'b0;
        end else begin
            loading_r <= loading;
            ld.wr_stb <= 1'b0;
            if (load_start) begin
                hdr_cnt   <= '0;
                load_addr <= '0;
                loaded    <= 1'b0;
            end
            if (~loading & loading_r)
                loaded <= 1'b1;     // Image complete
            if (take_byte) begin
                if (!hdr_done) begin
                    hdr_cnt <= hdr_cur + 1'b1;
                end else begin
                    load_addr <= addr_cur + 1'b1;
                    ld.wr_stb <= addr_cur[0];   // Second byte of a pair
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (take_byte && hdr_done) begin
            prev_byte <= loader_byte;
            if (addr_cur[0]) begin
                ld.wr_addr          <= {addr_cur[`ROM_ADDR_W-1:1], 1'b0};
                ld.wr_data.bytes[0] <= prev_byte;
                ld.wr_data.bytes[1] <= loader_byte;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

module rv_bridge (
    input  logic                        mclk,
    input  logic                        resetn,
    input  logic                        rv_valid,
    output logic                        rv_ready,
    input  logic [`ROM_ADDR_W-1:0]      rv_addr,
    input  logic [`RV_DATA_W-1:0]       rv_wdata,
    input  logic [3:0]                  rv_wstrb,
    output logic [`RV_DATA_W-1:0]       rv_rdata,
    output logic                        rv_req,
    output logic                        rv_we,
    input  logic                        rv_req_ack,
    output logic [`ROM_ADDR_W-2:0]      rv_mem_addr,
    output snes_mem_pkg::sdram_word_u   rv_din,
    output logic [1:0]                  rv_ds,
    input  snes_mem_pkg::sdram_word_u   rv_dout
);
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_WAIT0  = 3'd1;   // Lower half in flight
    localparam logic [2:0] ST_DATA0  = 3'd2;
    localparam logic [2:0] ST_WAIT1  = 3'd3;   // Upper half in flight
    localparam logic [2:0] ST_FINISH = 3'd4;

    logic [2:0]                 state;
    logic                       rv_valid_r;
    logic                       pend;
    logic                       new_req;
    logic                       start;
    logic                       write;
    logic                       ack_ok;
    logic                       rv_word;        // Half being accessed
    logic [`SDRAM_DATA_W-1:0]   low_half;

    assign new_req = rv_valid & ~rv_valid_r;
    assign start   = new_req | pend;
    assign write   = |rv_wstrb;
    assign ack_ok  = rv_req == rv_req_ack;

    assign rv_we       = write;
    assign rv_mem_addr = {rv_addr[`ROM_ADDR_W-1:2], rv_word};
    assign rv_din.word = rv_word ? rv_wdata[`RV_DATA_W-1:`SDRAM_DATA_W]
                                 : rv_wdata[`SDRAM_DATA_W-1:0];
    assign rv_rdata    = {rv_dout.word, low_half};

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            rv_ready   <= 1'b0;
            rv_req     <= 1'b0;
            rv_valid_r <= 1'b0;
            pend       <= 1'b0;
        end else begin
            rv_valid_r <= rv_valid;
            rv_ready   <= 1'b0;
            if (new_req)
                pend <= 1'b1;   // Held until the FSM is free

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        pend   <= 1'b0;
                        rv_req <= ~rv_req;
                        if (write && rv_wstrb[1:0] == 2'b00) begin
                            rv_word <= 1'b1;        // Upper half only
                            rv_ds   <= rv_wstrb[3:2];
                            state   <= ST_WAIT1;
                        end else begin
                            rv_word <= 1'b0;
                            rv_ds   <= write ? rv_wstrb[1:0] : 2'b11;
                            state   <= ST_WAIT0;
                        end
                    end
                end

                ST_WAIT0: begin
                    if (ack_ok) begin
                        if (!write) begin
                            state <= ST_DATA0;
                        end else if (rv_wstrb[3:2] == 2'b00) begin
                            rv_ready <= 1'b1;       // Lower half was enough
                            state    <= ST_IDLE;
                        end else begin
                            rv_req  <= ~rv_req;
                            rv_word <= 1'b1;
                            rv_ds   <= rv_wstrb[3:2];
                            state   <= ST_WAIT1;
                        end
                    end
                end

                ST_DATA0: begin
                    low_half <= rv_dout.word;
                    rv_req   <= ~rv_req;
                    rv_word  <= 1'b1;
                    rv_ds    <= 2'b11;
                    state    <= ST_WAIT1;
                end

                ST_WAIT1: begin
                    if (ack_ok) begin
                        if (write) begin
                            rv_ready <= 1'b1;
                            state    <= ST_IDLE;
                        end else begin
                            state <= ST_FINISH;
                        end
                    end
                end

                ST_FINISH: begin
                    rv_ready <= 1'b1;   // Upper half still on rv_dout
                    state    <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/snes_mem_pkg.sv ====
`default_nettype none

`include "snes_mem_settings.svh"

package snes_mem_pkg;

    // One SDRAM word as it comes back from the controller.
    // ROM reads use it whole or byte swapped, WRAM picks a single lane.
    typedef union packed {
        logic [`SDRAM_DATA_W-1:0]          word;
        logic [`SDRAM_DATA_W/8-1:0][7:0]   bytes;  // bytes[0] is the low lane
    } sdram_word_u;

endpackage

`default_nettype wire

// ==== hdl/snes_mem_settings.svh ====
`ifndef SNES_MEM_SETTINGS_SVH
`define SNES_MEM_SETTINGS_SVH

// SNES ROM byte address, also covers the whole SDRAM byte space
`define ROM_ADDR_W      23

// WRAM byte address, 128 KB
`define WRAM_ADDR_W     17

// Upper address bits that put WRAM at the top 128 KB of SDRAM
`define WRAM_BASE_TAG   6'b111111

// Leading image bytes dropped before the ROM data
`define HEADER_BYTES    64

// One SDRAM word
`define SDRAM_DATA_W    16

// Softcore bus word, two SDRAM words
`define RV_DATA_W       32

`endif

// ==== hdl/snes_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

module snes_mem_top (
    input  logic                        mclk,
    input  logic                        resetn,

    // Image stream
    input  logic                        loading,
    input  logic [7:0]                  loader_byte,
    input  logic                        loader_byte_valid,
    output logic                        loaded,

    // SNES ROM and WRAM
    input  logic [`ROM_ADDR_W-1:0]      rom_addr,
    input  logic                        rom_ce_n,
    input  logic                        rom_word,
    output logic [`SDRAM_DATA_W-1:0]    rom_q,
    input  logic [`WRAM_ADDR_W-1:0]     wram_addr,
    input  logic                        wram_ce_n,
    input  logic                        wram_rd_n,
    input  logic                        wram_we_n,
    input  logic [7:0]                  wram_d,
    output logic [7:0]                  wram_q,

    // SDRAM CPU channel
    output logic                        cpu_req,
    output logic [`ROM_ADDR_W-2:0]      cpu_addr,
    output logic [`SDRAM_DATA_W-1:0]    cpu_din,
    output logic [1:0]                  cpu_ds,
    output logic                        cpu_we,
    output logic                        cpu_port,
    input  logic [`SDRAM_DATA_W-1:0]    cpu_port0,
    input  logic [`SDRAM_DATA_W-1:0]    cpu_port1,

    // Softcore bus
    input  logic                        rv_valid,
    output logic                        rv_ready,
    input  logic [`ROM_ADDR_W-1:0]      rv_addr,
    input  logic [`RV_DATA_W-1:0]       rv_wdata,
    input  logic [3:0]                  rv_wstrb,
    output logic [`RV_DATA_W-1:0]       rv_rdata,

    // SDRAM softcore channel
    output logic                        rv_req,
    output logic [`ROM_ADDR_W-2:0]      rv_mem_addr,
    output logic [`SDRAM_DATA_W-1:0]    rv_din,
    output logic [1:0]                  rv_ds,
    output logic                        rv_we,
    input  logic                        rv_req_ack,
    input  logic [`SDRAM_DATA_W-1:0]    rv_dout
);
    loader_if ld_bus ();

    rom_loader u_loader (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .loader_byte(loader_byte),
        .loader_byte_valid(loader_byte_valid), .loaded(loaded),
        .ld(ld_bus)
    );

    cpu_channel u_cpu (
        .mclk(mclk), .resetn(resetn), .ld(ld_bus),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word), .rom_q(rom_q),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d), .wram_q(wram_q),
        .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_port(cpu_port), .cpu_addr(cpu_addr),
        .cpu_din(cpu_din), .cpu_ds(cpu_ds), .cpu_port0(cpu_port0), .cpu_port1(cpu_port1)
    );

    rv_bridge u_rv (
        .mclk(mclk), .resetn(resetn),
        .rv_valid(rv_valid), .rv_ready(rv_ready), .rv_addr(rv_addr),
        .rv_wdata(rv_wdata), .rv_wstrb(rv_wstrb), .rv_rdata(rv_rdata),
        .rv_req(rv_req), .rv_we(rv_we), .rv_req_ack(rv_req_ack),
        .rv_mem_addr(rv_mem_addr), .rv_din(rv_din), .rv_ds(rv_ds), .rv_dout(rv_dout)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench, the exit status follows the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f snes_mem.f --top-module tb_snes_mem -o sim_snes_mem \
    && ./obj_dir/sim_snes_mem \
    || exit 1

// ==== snes_mem.f ====
+incdir+hdl
hdl/snes_mem_pkg.sv
hdl/loader_if.sv
hdl/rom_loader.sv
hdl/cpu_channel.sv
hdl/rv_bridge.sv
hdl/snes_mem_top.sv
tb/sdram_model.sv
tb/tb_snes_mem.sv

// ==== tb/sdram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

module sdram_model (
    input  logic                        mclk,
    input  logic                        resetn,
    input  logic                        cpu_req,
    input  logic [`ROM_ADDR_W-2:0]      cpu_addr,
    input  snes_mem_pkg::sdram_word_u   cpu_din,
    input  logic [1:0]                  cpu_ds,
    input  logic                        cpu_we,
    input  logic                        cpu_port,
    output snes_mem_pkg::sdram_word_u   cpu_port0,
    output snes_mem_pkg::sdram_word_u   cpu_port1,
    input  logic                        rv_req,
    input  logic [`ROM_ADDR_W-2:0]      rv_mem_addr,
    input  snes_mem_pkg::sdram_word_u   rv_din,
    input  logic [1:0]                  rv_ds,
    input  logic                        rv_we,
    output logic                        rv_req_ack,
    output snes_mem_pkg::sdram_word_u   rv_dout
);
    integer seed = 32'hfd8b_c749;

    logic [`SDRAM_DATA_W-1:0]   mem [0:(1<<(`ROM_ADDR_W-1))-1];
    logic                       cpu_seen;
    logic                       rv_seen;
    int                         cpu_cnt;
    int                         rv_cnt;
    logic [`ROM_ADDR_W-2:0]     c_addr;     // CPU request as latched
    snes_mem_pkg::sdram_word_u  c_din;
    logic [1:0]                 c_ds;
    logic                       c_we;
    logic                       c_port;
    logic [`ROM_ADDR_W-2:0]     r_addr;     // Softcore request as latched
    snes_mem_pkg::sdram_word_u  r_din;
    logic [1:0]                 r_ds;
    logic                       r_we;
    logic                       r_req;

    function automatic snes_mem_pkg::sdram_word_u merge_bytes(
        input snes_mem_pkg::sdram_word_u old_w,
        input snes_mem_pkg::sdram_word_u new_w,
        input logic [1:0] ds
    );
        snes_mem_pkg::sdram_word_u res;
        res.bytes[0] = ds[0] ? new_w.bytes[0] : old_w.bytes[0];
        res.bytes[1] = ds[1] ? new_w.bytes[1] : old_w.bytes[1];
        return res;
    endfunction

    always @(posedge mclk) begin
        if (!resetn) begin
            cpu_seen   <= 1'b0;
            rv_seen    <= 1'b0;
            cpu_cnt    <= 0;
            rv_cnt     <= 0;
            rv_req_ack <= 1'b0;
            cpu_port0  <= '0;
            cpu_port1  <= '0;
            rv_dout    <= '0;
        end else begin
            if (cpu_cnt == 1) begin
                if (c_we)
                    mem[c_addr] = merge_bytes(mem[c_addr], c_din, c_ds);
                if (c_port)
                    cpu_port1 <= mem[c_addr];
                else
                    cpu_port0 <= mem[c_addr];
            end
            if (cpu_cnt != 0)
                cpu_cnt <= cpu_cnt - 1;
            if (cpu_req != cpu_seen) begin  // Fixed two-cycle answer
                cpu_seen <= cpu_req;
                cpu_cnt  <= 2;
                c_addr   <= cpu_addr;
                c_din    <= cpu_din;
                c_ds     <= cpu_ds;
                c_we     <= cpu_we;
                c_port   <= cpu_port;
            end

            if (rv_cnt == 1) begin
                if (r_we)
                    mem[r_addr] = merge_bytes(mem[r_addr], r_din, r_ds);
                rv_dout    <= mem[r_addr];
                rv_req_ack <= r_req;
            end
            if (rv_cnt != 0)
                rv_cnt <= rv_cnt - 1;
            if (rv_req != rv_seen) begin
                rv_seen <= rv_req;
                rv_cnt  <= 3 + ($random(seed) & 3);     // Three to six cycles
                r_addr  <= rv_mem_addr;
                r_din   <= rv_din;
                r_ds    <= rv_ds;
                r_we    <= rv_we;
                r_req   <= rv_req;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/snes_mem_cases.txt ====
# name kind addr data flag expected, all numbers hex
# load: addr is the image length, data the header fill byte, flag unused
load_image load 40 ee 0 1
rom_even rom_rd 10 0 1 3431
rom_odd rom_rd 11 0 0 3134
rom_even2 rom_rd 20 0 1 6461
rom_odd2 rom_rd 21 0 0 6164
wram_lo wram_wr 40 5a 0 0
wram_hi wram_wr 41 c3 0 0
wram_rd_lo wram_rd 40 0 0 5a
wram_over wram_wr 40 77 0 0
wram_keep_hi wram_rd 41 0 0 c3
wram_new_lo wram_rd 40 0 0 77
rv_full_wr rv_wr 200100 11223344 f 0
rv_full_rd rv_rd 200100 0 0 11223344
rv_up_wr rv_wr 200100 aabb0000 c 0
rv_up_rd rv_rd 200100 0 0 aabb3344
rv_lo_wr rv_wr 200100 00005566 3 0
rv_lo_rd rv_rd 200100 0 0 aabb5566
rv_wram_wr rv_wr 7e0100 ddccbbaa f 0
wram_sep0 wram_rd 100 0 0 aa
wram_sep1 wram_rd 101 0 0 bb
wram_sep3 wram_rd 103 0 0 dd

// ==== tb/tb_snes_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_settings.svh"

module tb_snes_mem;
    logic mclk, resetn, loading, loader_byte_valid, loaded;
    logic [7:0] loader_byte, wram_d, wram_q;
    logic [`ROM_ADDR_W-1:0] rom_addr, rv_addr;
    logic rom_ce_n, rom_word, wram_ce_n, wram_rd_n, wram_we_n;
    logic [`SDRAM_DATA_W-1:0] rom_q, cpu_din, cpu_port0, cpu_port1, rv_din, rv_dout;
    logic [`WRAM_ADDR_W-1:0] wram_addr;
    logic cpu_req, cpu_we, cpu_port, rv_valid, rv_ready, rv_req, rv_we, rv_req_ack;
    logic [`ROM_ADDR_W-2:0] cpu_addr, rv_mem_addr;
    logic [1:0] cpu_ds, rv_ds;
    logic [3:0] rv_wstrb;
    logic [`RV_DATA_W-1:0] rv_wdata, rv_rdata;

    string       case_name [0:63];
    string       case_kind [0:63];
    logic [31:0] case_addr [0:63];
    logic [31:0] case_data [0:63];
    logic [31:0] case_flag [0:63];
    logic [31:0] case_exp  [0:63];
    int          n_cases = 0;
    int          load_len = 0;
    logic        cases_ready = 1'b0;

    snes_mem_top dut0 (.*);

    sdram_model u_sdram (
        .mclk(mclk), .resetn(resetn),
        .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_ds(cpu_ds),
        .cpu_we(cpu_we), .cpu_port(cpu_port), .cpu_port0(cpu_port0), .cpu_port1(cpu_port1),
        .rv_req(rv_req), .rv_mem_addr(rv_mem_addr), .rv_din(rv_din), .rv_ds(rv_ds),
        .rv_we(rv_we), .rv_req_ack(rv_req_ack), .rv_dout(rv_dout)
    );

    initial mclk = 1'b0;
    always #10 mclk = ~mclk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input snes_mem_pkg::sdram_word_u exp,
                              input snes_mem_pkg::sdram_word_u act);
        if (act.word !== exp.word)
            stop_run($sformatf("Mismatch %s: expected %h actual %h", name, exp.word, act.word));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_run($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_rv(input string name, input logic [`RV_DATA_W-1:0] exp,
                            input logic [`RV_DATA_W-1:0] act);
        if (act !== exp)
            stop_run($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("Mismatch %s: expected %b actual %b", name, exp, act));
    endtask

    function automatic logic [7:0] image_byte(input int i);
        return 8'(i * 3 + 1);
    endfunction

    task automatic read_cases();
        int    fd;
        int    cnt;
        string line;
        string nm;
        string kd;
        logic [31:0] a, d, f, e;
        fd = $fopen("tb/snes_mem_cases.txt", "r");
        if (fd == 0)
            stop_run("Could not open the case file tb/snes_mem_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != 8'h23) begin     // Skip comment lines
                cnt = $sscanf(line, "%s %s %h %h %h %h", nm, kd, a, d, f, e);
                if (cnt == 6 && n_cases < 64) begin
                    case_name[n_cases] = nm;
                    case_kind[n_cases] = kd;
                    case_addr[n_cases] = a;
                    case_data[n_cases] = d;
                    case_flag[n_cases] = f;
                    case_exp[n_cases]  = e;
                    if (kd == "load")
                        load_len += 2 * (`HEADER_BYTES + int'(a)) + 20;
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_byte(input logic [7:0] b);
        loader_byte       <= b;
        loader_byte_valid <= 1'b1;
        @(posedge mclk);
        loader_byte_valid <= 1'b0;
        @(posedge mclk);    // Gap keeps SDRAM writes apart
    endtask

    task automatic load_image(input string name, input int nbytes, input logic [7:0] hdr,
                              input logic exp);
        int n;
        loading <= 1'b1;
        @(posedge mclk);
        for (int i = 0; i < `HEADER_BYTES; i++)
            send_byte(hdr);
        for (int i = 0; i < nbytes; i++)
            send_byte(image_byte(i));
        repeat (4) @(posedge mclk);
        loading <= 1'b0;
        n = 0;
        while (loaded !== 1'b1 && n < 10) begin
            @(posedge mclk);
            n++;
        end
        check_flag(name, exp, loaded);
    endtask

    // Request on the next edge, model answers two cycles after that
    task automatic rom_read(input string name, input logic [31:0] addr, input logic wordf,
                            input logic [15:0] exp);
        rom_addr <= addr[`ROM_ADDR_W-1:0];
        rom_word <= wordf;
        rom_ce_n <= 1'b0;
        repeat (6) @(posedge mclk);
        check_word(name, exp, rom_q);
        rom_ce_n <= 1'b1;
        @(posedge mclk);
    endtask

    task automatic wram_write(input logic [31:0] addr, input logic [7:0] data);
        wram_addr <= addr[`WRAM_ADDR_W-1:0];
        wram_d    <= data;
        wram_ce_n <= 1'b0;
        wram_we_n <= 1'b0;
        repeat (2) @(posedge mclk);
        wram_ce_n <= 1'b1;
        wram_we_n <= 1'b1;
        repeat (6) @(posedge mclk);
    endtask

    task automatic wram_read(input string name, input logic [31:0] addr, input logic [7:0] exp);
        wram_addr <= addr[`WRAM_ADDR_W-1:0];
        wram_ce_n <= 1'b0;
        wram_rd_n <= 1'b0;
        repeat (6) @(posedge mclk);
        check_byte(name, exp, wram_q);
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
        repeat (2) @(posedge mclk);
    endtask

    task automatic rv_access(input string name, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [31:0] exp);
        int n;
        rv_addr  <= addr[`ROM_ADDR_W-1:0];
        rv_wdata <= data;
        rv_wstrb <= strb;
        rv_valid <= 1'b1;
        n = 0;
        do begin
            @(posedge mclk);
            n++;
            if (n > 150)
                stop_run($sformatf("Softcore access %s never got rv_ready", name));
        end while (rv_ready !== 1'b1);
        if (strb == 4'b0000)
            check_rv(name, exp, rv_rdata);
        rv_valid <= 1'b0;
        repeat (4) begin    // Ready is a single pulse
            @(posedge mclk);
            check_flag(name, 1'b0, rv_ready);
        end
    endtask

    initial begin
        resetn <= 1'b0;
        loading <= 1'b0;
        loader_byte <= '0;
        loader_byte_valid <= 1'b0;
        rom_addr <= '0;
        rom_ce_n <= 1'b1;
        rom_word <= 1'b0;
        wram_addr <= '0;
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
        wram_we_n <= 1'b1;
        wram_d <= '0;
        rv_valid <= 1'b0;
        rv_addr <= '0;
        rv_wdata <= '0;
        rv_wstrb <= '0;
        read_cases();
        if (n_cases == 0)
            stop_run("The case file held no cases");
        cases_ready = 1'b1;
        repeat (4) @(posedge mclk);
        resetn <= 1'b1;
        repeat (2) @(posedge mclk);
        check_flag("reset_ready", 1'b0, rv_ready);
        check_flag("reset_loaded", 1'b0, loaded);
        for (int i = 0; i < n_cases; i++) begin
            if (case_kind[i] == "load")
                load_image(case_name[i], int'(case_addr[i]), case_data[i][7:0], case_exp[i][0]);
            else if (case_kind[i] == "rom_rd")
                rom_read(case_name[i], case_addr[i], case_flag[i][0], case_exp[i][15:0]);
            else if (case_kind[i] == "wram_wr")
                wram_write(case_addr[i], case_data[i][7:0]);
            else if (case_kind[i] == "wram_rd")
                wram_read(case_name[i], case_addr[i], case_exp[i][7:0]);
            else if (case_kind[i] == "rv_wr" || case_kind[i] == "rv_rd")
                rv_access(case_name[i], case_addr[i], case_data[i], case_flag[i][3:0],
                          case_exp[i]);
            else
                stop_run($sformatf("Case %s has an unknown kind", case_name[i]));
        end
        $display("No errors");
        $finish;
    end

    initial begin
        wait (cases_ready);
        repeat (n_cases * 200 + load_len) @(posedge mclk);
        $display("The run timed out before all cases finished");
        $display("Errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire
